// ==== testbench/dac_tests.txt ====
// Columns: cfg_src, cfg_pattern, cycle count, expected tx_data two cycles after apply
// tx_data is written channel 3 first, 16 hex digits per channel
00 1234 6 0000000000000000000000000000000000000000000000000000000000000000
55 1234 6 3434343412121212343434341212121234343434121212123434343412121212
11 a5c3 5 0000000000000000c3c3c3c3a5a5a5a50000000000000000c3c3c3c3a5a5a5a5
44 beef 5 efefefefbebebebe0000000000000000efefefefbebebebe0000000000000000
aa 0000 8 0001020300000000000102030000000000010203000000000001020300000000
55 ff00 4 00000000ffffffff00000000ffffffff00000000ffffffff00000000ffffffff
86 7e81 8 00010203000000000000000000000000818181817e7e7e7e0001020300000000
00 0000 4 0000000000000000000000000000000000000000000000000000000000000000

// ==== build.f ====
+incdir+hdl
hdl/dac_pkg.sv
hdl/dac_frame_if.sv
hdl/dac_dma_unpack.sv
hdl/dac_channel.sv
hdl/dac_jesd_framer.sv
hdl/dac_core.sv
testbench/dac_core_assert.sv
testbench/dac_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DAC core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module dac_core_tb \
  -f build.f \
  -o dac_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/dac_core_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit 1
fi

if echo "$output" | grep -q "Testbench passed"; then
  exit 0
fi

echo "Pass message not found"
exit 1

// ==== testbench/dac_core_tb.sv ====
// DAC core testbench

`timescale 1ns/100ps

`include "dac_defines.svh"

module dac_core_tb;

  localparam int NUM_RECORDS = 8;

  logic                       dac_clk;
  logic                       dac_rst;
  logic [2*`DAC_CHANNELS-1:0] cfg_src;
  logic [`DAC_SAMPLE_W-1:0]   cfg_pattern;
  logic [`DAC_LANE_W-1:0]     dma_data;
  logic                       dma_valid;
  logic                       dma_ready;
  logic                       dma_underflow;
  logic [`DAC_LANE_W-1:0]     tx_data;
  logic                       tx_valid;

  // Four entries per record hold source select, pattern, cycle count and first lane word
  logic [`DAC_LANE_W-1:0] tests_mem [0:4*NUM_RECORDS-1];

  // Model of the DMA buffer that is updated in the middle of every cycle
  logic                   model_full;
  logic [`DAC_LANE_W-1:0] model_word;
  logic                   model_underflow;
  logic                   last_xfer;
  logic                   dma_phase;
  int                     accepted_cnt;
  // Nonzero lane words seen on tx_data while DMA words are flowing
  int                     seen_cnt;

  // One expected lane word is pushed per cycle and checked two edges later
  logic [`DAC_LANE_W-1:0] exp_q [$];

  dac_core DUT (
    .dac_clk       (dac_clk),
    .dac_rst       (dac_rst),
    .cfg_src       (cfg_src),
    .cfg_pattern   (cfg_pattern),
    .dma_data      (dma_data),
    .dma_valid     (dma_valid),
    .dma_ready     (dma_ready),
    .dma_underflow (dma_underflow),
    .tx_data       (tx_data),
    .tx_valid      (tx_valid)
  );

  initial begin
    dac_clk = 1'b0;
    forever #50 dac_clk = ~dac_clk;
  end

  // ********************************************************************
  // Reporting
  // ********************************************************************

  task automatic report_value(input string name, input logic [255:0] got,
                              input logic [255:0] exp);
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Gave up waiting for %s at %0t ns", what, $time);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // ********************************************************************
  // Reference model
  // ********************************************************************

  // Builds the lane word from the channel source rules and the byte order
  // of device type 0 by going byte by byte through each channel
  function automatic logic [255:0] ref_lane(input logic [7:0] src, input logic [15:0] pat,
                                            input logic [15:0] r, input logic [255:0] dword,
                                            input logic dvld);
    logic [255:0] lane;
    logic [15:0]  smp;
    logic [1:0]   sel;
    int           s;
    lane = '0;
    for (int c = 0; c < 4; c++) begin
      sel = src[2*c +: 2];
      for (int b = 0; b < 8; b++) begin
        // Bytes 0..3 and 4..7 both walk samples 3, 2, 1, 0
        s = 3 - (b % 4);
        case (sel)
          2'd1:    smp = pat;
          2'd2:    smp = r + 16'(s);
          2'd3:    smp = dvld ? dword[64*c + 16*s +: 16] : 16'h0;
          default: smp = 16'h0;
        endcase
        lane[64*c + 8*b +: 8] = (b < 4) ? smp[15:8] : smp[7:0];
      end
    end
    return lane;
  endfunction

  function automatic logic [255:0] random_word();
    logic [255:0] w;
    w = '0;
    for (int i = 0; i < 8; i++) begin
      w[32*i +: 32] = $urandom();
    end
    return w;
  endfunction

  // Mid-cycle view of the handshake when all inputs have settled
  task automatic model_update();
    logic                   need;
    logic                   consume;
    logic                   ready;
    logic [`DAC_LANE_W-1:0] exp;
    need = 1'b0;
    for (int c = 0; c < 4; c++) begin
      if (cfg_src[2*c +: 2] == 2'd3) begin
        need = 1'b1;
      end
    end
    consume = need & model_full;
    ready   = ~model_full | consume;
    assert (dma_ready == ready) else report_value("dma_ready", 256'(dma_ready), 256'(ready));
    exp = ref_lane(cfg_src, cfg_pattern, 16'h0, model_word, consume);
    exp_q.push_back(exp);
    if (need && !model_full) begin
      model_underflow = 1'b1;
    end
    last_xfer = dma_valid & ready;
    if (last_xfer) begin
      model_full = 1'b1;
      model_word = dma_data;
      accepted_cnt++;
    end else if (consume) begin
      model_full = 1'b0;
    end
  endtask

  // One clock cycle that ends 1 ns after the rising edge where inputs change
  task automatic step();
    logic [`DAC_LANE_W-1:0] exp;
    @(negedge dac_clk);
    model_update();
    @(posedge dac_clk);
    #1;
    if (exp_q.size() == 2) begin
      exp = exp_q.pop_front();
      if (dma_phase) begin
        assert (tx_data == exp) else report_value("tx_data", tx_data, exp);
        assert (dma_underflow == model_underflow)
          else report_value("dma_underflow", 256'(dma_underflow), 256'(model_underflow));
        // Random DMA words are never all zero, unlike the idle frames between them
        if (tx_data != '0) begin
          seen_cnt++;
        end
      end
    end
  endtask

  // Holds the word until it is taken, then offers a new one or a gap
  task automatic drive_dma(input logic gaps);
    if (!dma_valid || last_xfer) begin
      if (!gaps || ($urandom() & 32'd1) == 32'd1) begin
        dma_valid = 1'b1;
        dma_data  = random_word();
      end else begin
        dma_valid = 1'b0;
      end
    end
  endtask

  // ********************************************************************
  // Main sequence
  // ********************************************************************

  initial begin
    logic [`DAC_LANE_W-1:0] exp;
    logic [`DAC_LANE_W-1:0] file_exp;
    int                     cnt;
    int                     t;
    void'($urandom(32'h87d6945d));
    dac_rst         = 1'b1;
    cfg_src         = '0;
    cfg_pattern     = '0;
    dma_data        = '0;
    dma_valid       = 1'b0;
    model_full      = 1'b0;
    model_word      = '0;
    model_underflow = 1'b0;
    last_xfer       = 1'b0;
    dma_phase       = 1'b0;
    accepted_cnt    = 0;
    seen_cnt        = 0;
    $readmemh("testbench/dac_tests.txt", tests_mem);

    repeat (2) @(posedge dac_clk);
    #1;
    assert (tx_data == '0) else report_value("tx_data", tx_data, '0);
    assert (tx_valid == 1'b0) else report_value("tx_valid", 256'(tx_valid), 256'd0);
    assert (dma_ready == 1'b1) else report_value("dma_ready", 256'(dma_ready), 256'd1);
    assert (dma_underflow == 1'b0)
      else report_value("dma_underflow", 256'(dma_underflow), 256'd0);
    dac_rst = 1'b0;

    t = 0;
    while (!tx_valid) begin
      step();
      t++;
      if (t > 10) report_timeout("tx_valid after reset");
    end

    // Constant, zero and ramp records from the data file
    for (int i = 0; i < NUM_RECORDS; i++) begin
      cfg_src     = tests_mem[4*i][7:0];
      cfg_pattern = tests_mem[4*i+1][15:0];
      cnt         = int'(tests_mem[4*i+2][31:0]);
      file_exp    = tests_mem[4*i+3];
      step();
      step();
      exp = ref_lane(cfg_src, cfg_pattern, 16'h0, '0, 1'b0);
      assert (exp == file_exp) else report_value("record lane word", file_exp, exp);
      assert (tx_data == exp) else report_value("tx_data", tx_data, exp);
      for (int k = 1; k < cnt; k++) begin
        step();
        exp = ref_lane(cfg_src, cfg_pattern, 16'(4*k), '0, 1'b0);
        assert (tx_data == exp) else report_value("tx_data", tx_data, exp);
      end
    end

    // DMA with a steady source fills the buffer before any demand
    cfg_src   = 8'h00;
    dma_phase = 1'b1;
    drive_dma(1'b0);
    step();
    cfg_src = 8'hff;
    for (int k = 0; k < 16; k++) begin
      drive_dma(1'b0);
      step();
    end
    assert (dma_underflow == 1'b0)
      else report_value("dma_underflow", 256'(dma_underflow), 256'd0);

    // DMA with random gaps on dma_valid
    for (int k = 0; k < 40; k++) begin
      drive_dma(1'b1);
      step();
    end

    // Let the last offered word in, then drain the buffer
    t = 0;
    while (dma_valid) begin
      step();
      if (last_xfer) dma_valid = 1'b0;
      t++;
      if (t > 10) report_timeout("dma_ready on the last word");
    end
    t = 0;
    while (model_full) begin
      step();
      t++;
      if (t > 10) report_timeout("the DMA buffer to drain");
    end
    cfg_src = 8'h00;
    repeat (3) step();
    assert (seen_cnt == accepted_cnt)
      else report_value("DMA words on tx_data", 256'(seen_cnt), 256'(accepted_cnt));
    assert (dma_underflow == 1'b1)
      else report_value("dma_underflow", 256'(dma_underflow), 256'd1);

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== testbench/dac_core_assert.sv ====
// DAC core protocol assertions

`timescale 1ns/100ps

`include "dac_defines.svh"

module dac_core_assert (
  input logic                   dac_clk,
  input logic                   dac_rst,
  input logic                   dma_valid,
  input logic                   dma_ready,
  input logic                   dma_underflow,
  input logic [`DAC_LANE_W-1:0] tx_data,
  input logic                   tx_valid
);

  // Outputs hold their reset values on the edge after a reset cycle
  a_reset_values: assert property (@(posedge dac_clk)
    $past(dac_rst) |-> (tx_data == '0 && !tx_valid && dma_ready && !dma_underflow))
    else $error("Output not at its reset value");

  // A ready buffer stays ready until a word is taken
  a_ready_holds: assert property (@(posedge dac_clk) disable iff (dac_rst)
    dma_ready && !dma_valid |=> dma_ready)
    else $error("dma_ready fell without a transfer");

  // Underflow is sticky
  a_underflow_sticky: assert property (@(posedge dac_clk) disable iff (dac_rst)
    dma_underflow |=> dma_underflow)
    else $error("dma_underflow cleared outside reset");

endmodule

bind dac_core dac_core_assert u_core_assert (
  .dac_clk       (dac_clk),
  .dac_rst       (dac_rst),
  .dma_valid     (dma_valid),
  .dma_ready     (dma_ready),
  .dma_underflow (dma_underflow),
  .tx_data       (tx_data),
  .tx_valid      (tx_valid)
);

// ==== hdl/dac_core.sv ====
// DAC transmit data path top level

`timescale 1ns/100ps

`include "dac_defines.svh"

module dac_core
  import dac_pkg::*;
#(
  // Converter byte order variant, passed down to the framer
  parameter int DEVICE_TYPE = `DAC_DEVICE_TYPE
) (
  input  logic                       dac_clk,
  input  logic                       dac_rst,
  input  logic [2*`DAC_CHANNELS-1:0] cfg_src,
  input  logic [`DAC_SAMPLE_W-1:0]   cfg_pattern,
  input  logic [`DAC_LANE_W-1:0]     dma_data,
  input  logic                       dma_valid,
  output logic                       dma_ready,
  output logic                       dma_underflow,
  output logic [`DAC_LANE_W-1:0]     tx_data,
  output logic                       tx_valid
);

  localparam int SRC_W = $bits(dac_src_e);

  // DMA words toward the channels, and channel samples toward the framer
  dac_frame_if dma_frame (.dac_clk(dac_clk), .dac_rst(dac_rst));
  dac_frame_if chan_frame (.dac_clk(dac_clk), .dac_rst(dac_rst));

  // Each channel drives its own slice of these nets
  wire [`DAC_CHANNELS-1:0][`DAC_SAMPLES*`DAC_SAMPLE_W-1:0] chan_samples;
  wire [`DAC_CHANNELS-1:0]                                 chan_valid;

  // Single entry DMA buffer shared by all channels
  dac_dma_unpack u_dma_unpack (
    .dac_clk       (dac_clk),
    .dac_rst       (dac_rst),
    .cfg_src       (cfg_src),
    .dma_data      (dma_data),
    .dma_valid     (dma_valid),
    .dma_ready     (dma_ready),
    .dma_underflow (dma_underflow),
    .frame         (dma_frame)
  );

  // One channel per converter input, two select bits each
  for (genvar g = 0; g < `DAC_CHANNELS; g++) begin : g_chan
    dac_channel #(
      .CHANNEL (g)
    ) u_channel (
      .dac_clk   (dac_clk),
      .dac_rst   (dac_rst),
      .src       (dac_src_e'(cfg_src[SRC_W*g +: SRC_W])),
      .pattern   (cfg_pattern),
      .dma_frame (dma_frame),
      .samples   (chan_samples[g]),
      .out_valid (chan_valid[g])
    );
  end

  // All channels leave reset together, so channel 0 speaks for the frame
  assign chan_frame.frame = chan_samples;
  assign chan_frame.valid = chan_valid[0];

  dac_jesd_framer #(
    .DEVICE_TYPE (DEVICE_TYPE)
  ) u_framer (
    .dac_clk  (dac_clk),
    .dac_rst  (dac_rst),
    .frame    (chan_frame),
    .tx_data  (tx_data),
    .tx_valid (tx_valid)
  );

endmodule

// ==== hdl/dac_jesd_framer.sv ====
// JESD lane word framer

`timescale 1ns/100ps

`include "dac_defines.svh"

module dac_jesd_framer #(
  // Byte order variant of the attached converter, 0 or 1
  parameter int DEVICE_TYPE = `DAC_DEVICE_TYPE
) (
  input  logic                   dac_clk,
  input  logic                   dac_rst,
  dac_frame_if.sink              frame,
  output logic [`DAC_LANE_W-1:0] tx_data,
  output logic                   tx_valid
);

  // Bits per channel on the lane and the byte offset of the low half
  localparam int CH_W   = `DAC_SAMPLES * `DAC_SAMPLE_W;
  localparam int HALF_W = CH_W / 2;

  // Lane word before the output register
  logic [`DAC_LANE_W-1:0] lane;

  // ********************************************************************
  // Byte ordering
  // ********************************************************************

  // Channel c fills lane bits 64c up to 64c+63
  // The lower four bytes hold the sample high bytes and the upper four
  // the low bytes, in the same sample order for both halves
  // Variant 0 runs samples 3, 2, 1, 0 upward and variant 1 runs 0 to 3
  always_comb begin
    int idx;
    lane = '0;
    for (int c = 0; c < `DAC_CHANNELS; c++) begin
      for (int k = 0; k < `DAC_SAMPLES; k++) begin
        if (DEVICE_TYPE == 1) begin
          idx = k;
        end else begin
          idx = `DAC_SAMPLES - 1 - k;
        end
        lane[CH_W*c + 8*k +: 8]          = frame.frame[c][idx][15:8];
        lane[CH_W*c + HALF_W + 8*k +: 8] = frame.frame[c][idx][7:0];
      end
    end
  end

  // ********************************************************************
  // Output register
  // ********************************************************************

  // The link takes a word on every cycle, so there is no stall path
  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      tx_data  <= '0;
      tx_valid <= 1'b0;
    end else begin
      tx_data  <= lane;
      tx_valid <= frame.valid;
    end
  end

endmodule

// ==== hdl/dac_channel.sv ====
// DAC channel sample source

`timescale 1ns/100ps

`include "dac_defines.svh"

module dac_channel
  import dac_pkg::*;
#(
  // Index of this channel, selects its slice of the DMA frame
  parameter int CHANNEL = 0
) (
  input  logic                                 dac_clk,
  input  logic                                 dac_rst,
  input  dac_src_e                             src,
  input  logic [`DAC_SAMPLE_W-1:0]             pattern,
  dac_frame_if.sink                            dma_frame,
  output logic [`DAC_SAMPLES*`DAC_SAMPLE_W-1:0] samples,
  output logic                                 out_valid
);

  localparam int SW = `DAC_SAMPLE_W;

  // The ramp moves on by one sample slot per sample per cycle
  localparam logic [SW-1:0] RAMP_STEP = SW'(`DAC_SAMPLES);

  // Four samples for the next cycle, sample 0 in the low bits
  logic [`DAC_SAMPLES-1:0][SW-1:0] next_samples;

  // First ramp value of the current cycle
  logic [SW-1:0]                   ramp_cnt;

  // ********************************************************************
  // Source selection
  // ********************************************************************

  always_comb begin
    next_samples = '0;
    case (src)
      SRC_ZERO: begin
        next_samples = '0;
      end
      SRC_CONST: begin
        // Same pattern word in every sample slot
        for (int s = 0; s < `DAC_SAMPLES; s++) begin
          next_samples[s] = pattern;
        end
      end
      SRC_RAMP: begin
        // Consecutive values r, r+1, r+2, r+3, wrapping at 16 bits
        for (int s = 0; s < `DAC_SAMPLES; s++) begin
          next_samples[s] = ramp_cnt + SW'(s);
        end
      end
      SRC_DMA: begin
        // Zeros are sent on any cycle without a consumed DMA word
        if (dma_frame.valid) begin
          next_samples = dma_frame.frame[CHANNEL];
        end
      end
      default: begin
        next_samples = '0;
      end
    endcase
  end

  // ********************************************************************
  // Ramp counter
  // ********************************************************************

  // Leaving ramp mode restarts the ramp from zero on the next entry
  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      ramp_cnt <= '0;
    end else if (src == SRC_RAMP) begin
      ramp_cnt <= ramp_cnt + RAMP_STEP;
    end else begin
      ramp_cnt <= '0;
    end
  end

  // ********************************************************************
  // Output register
  // ********************************************************************

  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      samples   <= '0;
      out_valid <= 1'b0;
    end else begin
      samples   <= next_samples;
      // Rises on the first clock out of reset and then stays high
      out_valid <= 1'b1;
    end
  end

endmodule

// ==== hdl/dac_dma_unpack.sv ====
// DMA word buffer

`timescale 1ns/100ps

`include "dac_defines.svh"

module dac_dma_unpack
  import dac_pkg::*;
(
  input  logic                           dac_clk,
  input  logic                           dac_rst,
  input  logic [2*`DAC_CHANNELS-1:0]     cfg_src,
  input  logic [`DAC_LANE_W-1:0]         dma_data,
  input  logic                           dma_valid,
  output logic                           dma_ready,
  output logic                           dma_underflow,
  dac_frame_if.src                       frame
);

  localparam int SRC_W = $bits(dac_src_e);

  // One entry buffer, the data word itself carries no reset
  dac_frame_t buf_data;
  logic       buf_full;

  // At least one channel wants DMA samples in this cycle
  logic       dma_need;
  logic       consume;
  logic       xfer;

  // ********************************************************************
  // Demand and handshake
  // ********************************************************************

  // Any channel on the DMA source makes the whole word be used up
  always_comb begin
    dma_need = 1'b0;
    for (int c = 0; c < `DAC_CHANNELS; c++) begin
      if (dac_src_e'(cfg_src[SRC_W*c +: SRC_W]) == SRC_DMA) begin
        dma_need = 1'b1;
      end
    end
  end

  assign consume = dma_need & buf_full;

  // Ready while empty, or while the held word leaves in this same cycle
  assign dma_ready = ~buf_full | consume;
  assign xfer      = dma_valid & dma_ready;

  // ********************************************************************
  // Buffer state
  // ********************************************************************

  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      buf_full      <= 1'b0;
      dma_underflow <= 1'b0;
    end else begin
      // A new word refills the slot even when the old one is consumed now
      if (xfer) begin
        buf_full <= 1'b1;
      end else if (consume) begin
        buf_full <= 1'b0;
      end
      // Starved cycle, sticky until the next reset
      if (dma_need && !buf_full) begin
        dma_underflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (xfer) begin
      buf_data <= dma_data;
    end
  end

  // The held word is offered to the channels straight from the buffer
  assign frame.frame = buf_data;
  assign frame.valid = consume;

endmodule

// ==== hdl/dac_frame_if.sv ====
// Sample frame interface

`timescale 1ns/100ps

interface dac_frame_if
  import dac_pkg::*;
(
  input logic dac_clk,
  input logic dac_rst
);

  // All sixteen samples of one clock cycle
  dac_frame_t frame;

  // High in a cycle that carries a frame worth using
  logic       valid;

  // Producer side of a pipeline stage
  modport src (
    input  dac_clk,
    input  dac_rst,
    output frame,
    output valid
  );

  // Consumer side, read only
  modport sink (
    input  dac_clk,
    input  dac_rst,
    input  frame,
    input  valid
  );

endinterface

// ==== hdl/dac_pkg.sv ====
// DAC core types

`include "dac_defines.svh"

package dac_pkg;

  // Data source of one channel, two bits per channel on cfg_src
  typedef enum logic [1:0] {
    SRC_ZERO  = 2'd0,
    SRC_CONST = 2'd1,
    SRC_RAMP  = 2'd2,
    SRC_DMA   = 2'd3
  } dac_src_e;

  // Full sample frame, indexed as frame[channel][sample]
  // Sample 0 of channel 0 sits in the lowest 16 bits
  typedef logic [`DAC_CHANNELS-1:0]
                [`DAC_SAMPLES-1:0]
                [`DAC_SAMPLE_W-1:0] dac_frame_t;

endpackage

// ==== hdl/dac_defines.svh ====
// DAC core sizing constants

`ifndef DAC_DEFINES_SVH
`define DAC_DEFINES_SVH

// ********************************************************************
// Data path dimensions
// ********************************************************************

// Number of converter channels served by the core
`define DAC_CHANNELS 4

// Samples produced per channel on every dac_clk cycle
`define DAC_SAMPLES 4

// Width of a single converter sample
`define DAC_SAMPLE_W 16

// One lane word carries all samples of all channels
`define DAC_LANE_W 256

// Byte order variant, 0 or 1, used when the top level gives none
`define DAC_DEVICE_TYPE 0

`endif
